// File: csr_index_generator.f
+incdir+verilog
verilog/csr_config_pkg.sv
verilog/mem_packet_pkg.sv
verilog/request_fifo_if.sv
verilog/index_sequencer.sv
verilog/request_formatter.sv
verilog/request_fifo.sv
verilog/csr_index_generator.sv
verif/csr_index_checker.sv
verif/tb_csr_index_generator.sv

// File: Makefile
# Verilator build and run of the CSR index generator testbench

TOP := tb_csr_index_generator
LOG := sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f csr_index_generator.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_csr_index_generator.sv
// Testbench for the CSR edge-index generator.
// Random direct-mode runs are checked word by word against a reference model
// of the index range and address rule, with steady or sparse consumer pops.

module tb_csr_index_generator;
    timeunit 1ns;
    timeprecision 100ps;

    logic                    ap_clk = 1'b0;
    logic                    areset_generator;
    logic                    start;
    logic                    count_down;
    logic                    shift_left;
    logic                    req_rd_en;
    csr_config_pkg::index_t  index_start;
    csr_config_pkg::index_t  index_end;
    csr_config_pkg::stride_t stride;
    mem_packet_pkg::addr_t   array_pointer;
    csr_config_pkg::shift_t  shift_amount;
    logic                    req_valid;
    logic                    req_last;
    logic                    done;
    mem_packet_pkg::addr_t   req_address;
    csr_config_pkg::index_t  req_index;

    // Expected requests, oldest first
    mem_packet_pkg::addr_t  exp_addr [$];
    csr_config_pkg::index_t exp_idx [$];
    logic                   exp_last [$];

    int          value_errors = 0;
    int          other_errors = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 100;
    logic [31:0] lfsr         = 32'h9380;

    csr_index_generator dut0 (.*);

    bind request_fifo csr_index_checker chk0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (fifo.wr_en),
        .full             (fifo.full),
        .prog_full        (fifo.prog_full),
        .rd_en            (rd_en),
        .empty            (empty),
        .rd_valid         (rd_valid)
    );

    always #2 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic report_counts();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, dut0.fifo0.chk0.fail_count);
    endtask

    task automatic configure(input logic [31:0] first, input logic [31:0] last_idx,
                             input logic [31:0] step, input logic [31:0] down,
                             input logic [31:0] base, input logic [31:0] left,
                             input logic [31:0] sh);
        index_start   = csr_config_pkg::index_t'(first);
        index_end     = csr_config_pkg::index_t'(last_idx);
        stride        = csr_config_pkg::stride_t'(step);
        count_down    = (down != 0);
        array_pointer = base;
        shift_left    = (left != 0);
        shift_amount  = csr_config_pkg::shift_t'(sh);
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Index walk in int so a step past either end of the index range just ends it
    task automatic build_model();
        int                    cur;
        mem_packet_pkg::addr_t offset;
        exp_addr.delete();
        exp_idx.delete();
        exp_last.delete();
        cur = int'(index_start);
        while (count_down ? (cur > int'(index_end)) : (cur < int'(index_end))) begin
            if (shift_left) begin
                offset = mem_packet_pkg::addr_t'(cur) << shift_amount;
            end else begin
                offset = mem_packet_pkg::addr_t'(cur) >> shift_amount;
            end
            exp_addr.push_back(array_pointer + offset);
            exp_idx.push_back(csr_config_pkg::index_t'(cur));
            exp_last.push_back(1'b0);
            cur = count_down ? cur - int'(stride) : cur + int'(stride);
        end
        if (exp_last.size() > 0) begin
            exp_last[exp_last.size() - 1] = 1'b1;
        end
    endtask

    task automatic check_output(input string name);
        if (req_valid) begin
            if (exp_idx.size() == 0) begin
                $display("%s: request for index %h arrived when none was due", name, req_index);
                other_errors++;
            end else begin
                if (req_index !== exp_idx[0]) begin
                    $display("ERR %s index: expected %h actual %h", name, exp_idx[0], req_index);
                    value_errors++;
                end
                if (req_address !== exp_addr[0]) begin
                    $display("ERR %s address: expected %h actual %h",
                             name, exp_addr[0], req_address);
                    value_errors++;
                end
                if (req_last !== exp_last[0]) begin
                    $display("ERR %s last: expected %b actual %b", name, exp_last[0], req_last);
                    value_errors++;
                end
                void'(exp_idx.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_last.pop_front());
            end
        end
    endtask

    // One run: start, consume until done, then check that done holds
    task automatic run_test(input string name, input int random_pops);
        int hold;
        build_model();
        cycle_limit += 40 * exp_idx.size() + 200;
        start = 1'b1;
        @(posedge ap_clk);
        #1;
        start = 1'b0;
        if (done) begin
            $display("%s: done still high after start", name);
            other_errors++;
        end
        while (!done) begin
            check_output(name);
            req_rd_en = (random_pops != 0) ? (rand_bits(4) == 0) : 1'b1;
            @(posedge ap_clk);
            #1;
        end
        if (exp_idx.size() != 0) begin
            $display("%s: done rose with %0d requests not yet read", name, exp_idx.size());
            other_errors++;
        end
        hold = 3 + rand_bits(3);
        repeat (hold) begin
            check_output(name);
            if (!done) begin
                $display("%s: done dropped before the next start", name);
                other_errors++;
            end
            req_rd_en = (rand_bits(1) != 0);
            @(posedge ap_clk);
            #1;
        end
    endtask

    initial begin
        logic [31:0] first;
        start = 1'b0;
        req_rd_en = 1'b0;
        configure(0, 0, 1, 0, 0, 0, 0);
        areset_generator = 1'b1;
        repeat (10) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        @(posedge ap_clk);
        #1;
        if (req_valid || done) begin
            $display("reset: req_valid or done is high after reset");
            other_errors++;
        end

        // --------------------
        // Directed ranges with random fields
        // --------------------
        first = rand_bits(8);
        configure(first, first + 20 + rand_bits(7), 1 + rand_bits(3), 0,
                  rand_bits(32), 1, rand_bits(3));
        run_test("count_up", 0);

        first = 300 + rand_bits(8);
        configure(first, first - 40 - rand_bits(7), 1 + rand_bits(3), 1,
                  rand_bits(32), 0, rand_bits(3));
        run_test("count_down", 0);

        first = rand_bits(6);
        configure(first, first + 150 + rand_bits(6), 1, 0, rand_bits(32), 1, rand_bits(3));
        run_test("back_pressure", 1);

        configure(500, 500 - rand_bits(4), 1 + rand_bits(3), 0, rand_bits(32), 1, 2);
        run_test("empty_up", 0);
        configure(100, 100 + rand_bits(4), 1 + rand_bits(3), 1, rand_bits(32), 0, 1);
        run_test("empty_down", 0);

        // Steps that carry or borrow out of the index range
        configure('hFF00, 'hFFFF, 'h0034, 0, rand_bits(32), 1, 3);
        run_test("wrap_up", 0);
        configure('h0040, 0, 'h0030, 1, rand_bits(32), 0, 2);
        run_test("wrap_down", 1);

        // Back-to-back runs started from DONE
        repeat (6) begin
            configure(rand_bits(10), rand_bits(10), 1 + rand_bits(4), rand_bits(1),
                      rand_bits(32), rand_bits(1), rand_bits(3));
            run_test("back_to_back", rand_bits(1));
        end

        report_counts();
        if (value_errors + other_errors + dut0.fifo0.chk0.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verif/csr_index_checker.sv
// Assertions on the request FIFO: push safety, pop-to-valid timing and the
// fill flags, checked against a fill level rebuilt from the handshakes.
// Bound into request_fifo by the testbench.

`include "csr_index_cfg.svh"

module csr_index_checker (
    input logic ap_clk,
    input logic areset_generator,
    input logic wr_en,
    input logic full,
    input logic prog_full,
    input logic rd_en,
    input logic empty,
    input logic rd_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failures so far, read by the testbench for its summary
    int fail_count = 0;

    // Words held, counted from pushes and pops alone
    int level;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            level <= 0;
        end else begin
            level <= level + int'(wr_en && (level < `CSR_FIFO_DEPTH))
                           - int'(rd_en && (level > 0));
        end
    end

    // Sequencer pauses early enough that a push never meets a full queue
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            wr_en |-> (level < `CSR_FIFO_DEPTH)
    ) else begin
        $error("push into a full request FIFO");
        fail_count++;
    end

    // rd_valid only one cycle after a pop of a non-empty queue
    valid_after_pop: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            rd_valid |-> $past(rd_en && (level > 0))
    ) else begin
        $error("rd_valid without a pop of a non-empty queue");
        fail_count++;
    end

    pop_gives_valid: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            (rd_en && (level > 0)) |=> rd_valid
    ) else begin
        $error("pop of a non-empty queue gave no rd_valid");
        fail_count++;
    end

    // --------------------
    // Threshold
    // --------------------
    prog_full_level: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            prog_full == (level >= `CSR_PROG_THRESH)
    ) else begin
        $error("prog_full does not match the fill level");
        fail_count++;
    end

    fill_flags: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
            (empty == (level == 0)) && (full == (level == `CSR_FIFO_DEPTH))
    ) else begin
        $error("empty or full does not match the fill level");
        fail_count++;
    end

endmodule

// File: verilog/csr_index_generator.sv
// Top level of the CSR edge-index generator in direct mode.
// A start strobe with a range, stride and address setup produces a stream of
// read requests; the consumer pops them with req_rd_en.

`include "csr_index_cfg.svh"

module csr_index_generator (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    start,
    input  logic                    count_down,
    input  logic                    shift_left,
    input  logic                    req_rd_en,
    input  csr_config_pkg::index_t  index_start,
    input  csr_config_pkg::index_t  index_end,
    input  csr_config_pkg::stride_t stride,
    input  mem_packet_pkg::addr_t   array_pointer,
    input  csr_config_pkg::shift_t  shift_amount,
    output logic                    req_valid,
    output logic                    req_last,
    output logic                    done,
    output mem_packet_pkg::addr_t   req_address,
    output csr_config_pkg::index_t  req_index
);

    logic                          idx_valid;
    logic                          idx_last;
    csr_config_pkg::index_t        idx;
    logic                          fifo_empty;
    mem_packet_pkg::request_word_t rd_word;

    request_fifo_if fifo_bus ();

    index_sequencer sequencer0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .count_down       (count_down),
        .prog_full        (fifo_bus.prog_full),
        .fifo_empty       (fifo_empty),
        .index_start      (index_start),
        .index_end        (index_end),
        .stride           (stride),
        .idx_valid        (idx_valid),
        .idx_last         (idx_last),
        .done             (done),
        .idx              (idx)
    );

    request_formatter formatter0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .idx_valid        (idx_valid),
        .idx_last         (idx_last),
        .shift_left       (shift_left),
        .idx              (idx),
        .array_pointer    (array_pointer),
        .shift_amount     (shift_amount),
        .fifo             (fifo_bus.writer)
    );

    request_fifo #(
        .DEPTH (`CSR_FIFO_DEPTH)
    ) fifo0 (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .rd_en            (req_rd_en),
        .fifo             (fifo_bus.queue),
        .empty            (fifo_empty),
        .rd_valid         (req_valid),
        .rd_data          (rd_word)
    );

    // Request word onto the output ports
    assign req_address = rd_word.address;
    assign req_index   = rd_word.index;
    assign req_last    = (rd_word.seq_state == mem_packet_pkg::LAST);

endmodule

// File: verilog/request_fifo.sv
// Synchronous circular FIFO holding request words for the consumer.
// prog_full rises at the configured fill level to throttle the sequencer.
// A pop of a non-empty queue presents the word with rd_valid one cycle later.

`include "csr_index_cfg.svh"

module request_fifo #(
    parameter int DEPTH = `CSR_FIFO_DEPTH
) (
    input  logic                          ap_clk,
    input  logic                          areset_generator,
    input  logic                          rd_en,
    request_fifo_if.queue                 fifo,
    output logic                          empty,
    output logic                          rd_valid,
    output mem_packet_pkg::request_word_t rd_data
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_packet_pkg::request_word_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // A push into a full queue is dropped
    assign push = fifo.wr_en & ~fifo.full;
    assign pop  = rd_en & ~empty;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= fifo.wr_data;
        end
        if (pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // --------------------
    // Pointers and fill
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty          = (count == '0);
    assign fifo.full      = (count == CNT_W'(DEPTH));
    assign fifo.prog_full = (count >= CNT_W'(`CSR_PROG_THRESH));

endmodule

// File: verilog/request_formatter.sv
// Turns each index into a memory read request over three register stages:
// shifted offset, base add, then word packing and the FIFO push.
// Base pointer and shift are captured when a run starts.

module request_formatter (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   start,
    input  logic                   idx_valid,
    input  logic                   idx_last,
    input  logic                   shift_left,
    input  csr_config_pkg::index_t idx,
    input  mem_packet_pkg::addr_t  array_pointer,
    input  csr_config_pkg::shift_t shift_amount,
    request_fifo_if.writer         fifo
);

    // Run configuration
    mem_packet_pkg::addr_t  base_q;
    csr_config_pkg::shift_t shift_q;
    logic                   shift_left_q;

    // Stage 1
    logic                   s1_valid;
    logic                   s1_last;
    csr_config_pkg::index_t s1_idx;
    mem_packet_pkg::addr_t  s1_offset;

    // Stage 2
    logic                   s2_valid;
    logic                   s2_last;
    csr_config_pkg::index_t s2_idx;
    mem_packet_pkg::addr_t  s2_address;

    always_ff @(posedge ap_clk) begin
        if (start) begin
            base_q       <= array_pointer;
            shift_q      <= shift_amount;
            shift_left_q <= shift_left;
        end
    end

    // --------------------
    // Valid pipeline
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            fifo.wr_en <= 1'b0;
        end else begin
            s1_valid   <= idx_valid;
            s2_valid   <= s1_valid;
            fifo.wr_en <= s2_valid;
        end
    end

    // --------------------
    // Payload pipeline
    // --------------------
    always_ff @(posedge ap_clk) begin
        // Widen first so left shifts keep their upper bits
        if (shift_left_q) begin
            s1_offset <= mem_packet_pkg::addr_t'(idx) << shift_q;
        end else begin
            s1_offset <= mem_packet_pkg::addr_t'(idx) >> shift_q;
        end
        s1_idx  <= idx;
        s1_last <= idx_last;

        s2_address <= base_q + s1_offset;
        s2_idx     <= s1_idx;
        s2_last    <= s1_last;

        fifo.wr_data.address   <= s2_address;
        fifo.wr_data.index     <= s2_idx;
        fifo.wr_data.seq_state <= s2_last ? mem_packet_pkg::LAST : mem_packet_pkg::RUNNING;
    end

endmodule

// File: verilog/index_sequencer.sv
// Walks the index range of one direct-mode run and emits one index per cycle.
// Pauses while the request FIFO is past its threshold, then waits for the
// pipeline and FIFO to empty before raising done.

module index_sequencer (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    start,
    input  logic                    count_down,
    input  logic                    prog_full,
    input  logic                    fifo_empty,
    input  csr_config_pkg::index_t  index_start,
    input  csr_config_pkg::index_t  index_end,
    input  csr_config_pkg::stride_t stride,
    output logic                    idx_valid,
    output logic                    idx_last,
    output logic                    done,
    output csr_config_pkg::index_t  idx
);

    localparam int IDX_W = $bits(csr_config_pkg::index_t);

    // Formatter depth, cycles from idx_valid to the FIFO push
    localparam logic [1:0] PIPE_FLUSH = 2'd3;

    csr_config_pkg::gen_state_e state;
    csr_config_pkg::gen_state_e next_state;

    // Latched range
    csr_config_pkg::index_t  cur_idx;
    csr_config_pkg::index_t  end_idx;
    csr_config_pkg::stride_t stride_q;
    logic                    down_q;

    logic                   start_accept;
    logic [IDX_W:0]         step_sum;
    csr_config_pkg::index_t next_idx;
    logic                   in_range;
    logic                   next_ended;
    logic [1:0]             drain_cnt;

    // --------------------
    // Stride counter
    // --------------------
    assign start_accept = start & ((state == csr_config_pkg::IDLE) |
                                   (state == csr_config_pkg::DONE));

    // Extra bit catches a carry or borrow out of the index range
    assign step_sum = down_q ? ({1'b0, cur_idx} - {1'b0, stride_q})
                             : ({1'b0, cur_idx} + {1'b0, stride_q});
    assign next_idx = step_sum[IDX_W-1:0];

    assign in_range = down_q ? (cur_idx > end_idx) : (cur_idx < end_idx);

    // Next step wraps or leaves the range, so the current index is the final one
    assign next_ended = step_sum[IDX_W] |
                        (down_q ? (next_idx <= end_idx) : (next_idx >= end_idx));

    always_ff @(posedge ap_clk) begin
        if (start_accept) begin
            cur_idx  <= index_start;
            end_idx  <= index_end;
            stride_q <= stride;
            down_q   <= count_down;
        end else if (idx_valid) begin
            cur_idx <= next_idx;
        end
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= csr_config_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csr_config_pkg::RESET: begin
                next_state = csr_config_pkg::IDLE;
            end
            csr_config_pkg::IDLE, csr_config_pkg::DONE: begin
                if (start_accept) begin
                    next_state = csr_config_pkg::START;
                end
            end
            csr_config_pkg::START: begin
                // Empty range skips straight to the drain
                next_state = in_range ? csr_config_pkg::BUSY : csr_config_pkg::DRAIN;
            end
            csr_config_pkg::BUSY: begin
                if (idx_valid & next_ended) begin
                    next_state = csr_config_pkg::DRAIN;
                end else if (prog_full) begin
                    next_state = csr_config_pkg::PAUSE;
                end
            end
            csr_config_pkg::PAUSE: begin
                if (!prog_full) begin
                    next_state = csr_config_pkg::BUSY;
                end
            end
            csr_config_pkg::DRAIN: begin
                if ((drain_cnt == 2'd0) & fifo_empty) begin
                    next_state = csr_config_pkg::DONE;
                end
            end
            default: begin
                next_state = csr_config_pkg::IDLE;
            end
        endcase
    end

    // Covers the words still in the formatter when DRAIN is entered
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            drain_cnt <= 2'd0;
        end else if ((next_state == csr_config_pkg::DRAIN) &
                     (state != csr_config_pkg::DRAIN)) begin
            drain_cnt <= PIPE_FLUSH;
        end else if (drain_cnt != 2'd0) begin
            drain_cnt <= drain_cnt - 2'd1;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    assign idx_valid = (state == csr_config_pkg::BUSY) & in_range & ~prog_full;
    assign idx_last  = idx_valid & next_ended;
    assign idx       = cur_idx;
    assign done      = (state == csr_config_pkg::DONE);

endmodule

// File: verilog/request_fifo_if.sv
// Push side of the request FIFO.
// The formatter writes request words; the FIFO reports its fill status back.

interface request_fifo_if;

    // Push strobe and the word it carries
    logic                          wr_en;
    mem_packet_pkg::request_word_t wr_data;

    // Fill status from the queue
    logic prog_full;
    logic full;

    modport writer (
        output wr_en,
        output wr_data,
        input  prog_full,
        input  full
    );

    modport queue (
        input  wr_en,
        input  wr_data,
        output prog_full,
        output full
    );

endinterface

// File: verilog/mem_packet_pkg.sv
// Types of a memory read request as it leaves the generator.
// A request word is what the formatter pushes and the consumer pops.

`include "csr_index_cfg.svh"

package mem_packet_pkg;

    // Byte address of one array element
    typedef logic [`CSR_ADDR_W-1:0] addr_t;

    // Marks the final request of a sequence
    typedef enum logic {
        RUNNING = 1'b0,
        LAST    = 1'b1
    } seq_state_e;

    // --------------------
    // FIFO word
    // --------------------
    // 32-bit address, 16-bit index and one state bit
    typedef struct packed {
        addr_t                 address;
        csr_config_pkg::index_t index;
        seq_state_e            seq_state;
    } request_word_t;

endpackage

// File: verilog/csr_config_pkg.sv
// Types describing a generator run: the index range, stride and shift,
// plus the state encoding of the index sequencer.
// Referenced with scoped names by the sequencer, formatter and top level.

`include "csr_index_cfg.svh"

package csr_config_pkg;

    // --------------------
    // Configuration fields
    // --------------------
    // Index into the CSR edge array
    typedef logic [`CSR_INDEX_W-1:0] index_t;

    // Counter step, same width as an index
    typedef logic [`CSR_INDEX_W-1:0] stride_t;

    // Left or right shift that turns an index into a byte offset
    typedef logic [`CSR_SHIFT_W-1:0] shift_t;

    // --------------------
    // Sequencer FSM
    // --------------------
    // DRAIN waits for the request pipeline and FIFO to empty
    typedef enum logic [2:0] {
        RESET = 3'd0,
        IDLE  = 3'd1,
        START = 3'd2,
        BUSY  = 3'd3,
        PAUSE = 3'd4,
        DRAIN = 3'd5,
        DONE  = 3'd6
    } gen_state_e;

endpackage

// File: verilog/csr_index_cfg.svh
// Build-time sizes for the CSR edge-index generator.
// Included by the packages and by modules that size storage or thresholds.

`ifndef CSR_INDEX_CFG_SVH
`define CSR_INDEX_CFG_SVH

// --------------------
// Datapath widths
// --------------------
// Vertex or edge index
`define CSR_INDEX_W 16

// Byte address into the graph arrays
`define CSR_ADDR_W 32

// Index-to-offset shift amount
`define CSR_SHIFT_W 3

// --------------------
// Request FIFO
// --------------------
`define CSR_FIFO_DEPTH 16

// Fill level that raises prog_full and pauses the sequencer
`define CSR_PROG_THRESH 8

`endif
